/* src/ffu_dp_pkg.sv */
package ffu_dp_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // datapath widths
   ////////////////////////////////////////////////////////////////////////////
   localparam int data_w = 64;   // one fp double word
   localparam int word_w = 32;   // half, used by singles

   ////////////////////////////////////////////////////////////////////////////
   // select encodings
   ////////////////////////////////////////////////////////////////////////////

   // frf read alignment
   typedef enum logic [1:0] {
      noshift     = 2'd0,   // double, or single already in place
      shift_right = 2'd1,   // upper word down to lower
      shift_left  = 2'd2    // lower word up to upper
   } frf_shift_e;

   // return data source and word flip
   typedef enum logic [1:0] {
      lsu_noflip = 2'd0,
      lsu_flip   = 2'd1,    // load low word into upper
      fpu_noflip = 2'd2,
      fpu_flip   = 2'd3     // fpu upper word into lower
   } ret_sel_e;

   // next value of the rs2/rd register
   typedef enum logic [1:0] {
      frf_read = 2'd0,      // aligned frf with sign substitution
      ret_data = 2'd1,
      keep     = 2'd2
   } rs2_sel_e;

   // store data sent to the lsu
   typedef enum logic [1:0] {sel_rs2, sel_rs1, sel_frf, sel_fsr} out_sel_e;

endpackage

/* src/fsr_pkg.sv */
package fsr_pkg;

   localparam int fsr_w = 28;    // stored bits, rest of the fsr reads zero
   localparam int n_thr = 4;
   localparam int thr_w = 2;

   ////////////////////////////////////////////////////////////////////////////
   // field positions in the stored 28-bit fsr
   ////////////////////////////////////////////////////////////////////////////
   localparam int fcc_hi_lsb = 22;   // fcc3, fcc2, fcc1
   localparam int fcc_hi_w   = 6;
   localparam int rnd_lsb    = 20;
   localparam int rnd_w      = 2;
   localparam int tem_lsb    = 15;
   localparam int tem_w      = 5;
   localparam int ftt_lsb    = 12;
   localparam int ftt_w      = 3;
   localparam int fcc0_lsb   = 10;   // same spot in the 64-bit image
   localparam int fcc0_w     = 2;
   localparam int aexc_lsb   = 5;
   localparam int cexc_lsb   = 0;
   localparam int exc_w      = 5;    // aexc and cexc alike

   // architectural positions in the 64-bit fsr image
   localparam int arch_fcc_hi_lsb = 32;
   localparam int arch_rnd_lsb    = 30;
   localparam int arch_tem_lsb    = 23;
   localparam int arch_ftt_lsb    = 14;
   localparam int arch_low_w      = 12;   // fcc0, aexc, cexc unmoved

   // fsr update per cycle
   typedef enum logic [1:0] {fsr_hold, fsr_ld, fsr_fpu} fsr_op_e;

endpackage

/* src/ffu_input_align.sv */
module ffu_input_align
   import ffu_dp_pkg::*;
   import fsr_pkg::*;
(
   input  logic                             rclk,
   input  logic                             rst_n,
   input  logic [data_w-1:0]                frf_data,
   input  frf_shift_e                       frf_shift,
   input  logic                             zero_low32,
   input  logic [data_w-1:0]                cpx_fpu_data,
   input  logic [data_w-1:0]                lsu_ld_data,
   input  ret_sel_e                         ret_sel,
   output logic [data_w-1:0]                frf_aligned,
   output logic [data_w-1:0]                ret_data,
   output logic [data_w-1:0]                ld_d1,
   output logic [fcc_hi_w+fcc0_w-1:0]       ld_fcc
);

   logic [data_w-1:0] fpu_d1;
   logic [data_w-1:0] frf_shifted;

   ////////////////////////////////////////////////////////////////////////////
   // return capture
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         ld_d1  <= '0;
         fpu_d1 <= '0;
      end else begin
         ld_d1  <= lsu_ld_data;
         fpu_d1 <= cpx_fpu_data;
      end
   end

   // fcc bits of an ldfsr, straight from the flopped load
   assign ld_fcc = {ld_d1[arch_fcc_hi_lsb +: fcc_hi_w], ld_d1[fcc0_lsb +: fcc0_w]};

   ////////////////////////////////////////////////////////////////////////////
   // frf read alignment
   ////////////////////////////////////////////////////////////////////////////
   // singles can sit in either half of the 64-bit read
   always_comb begin
      case (frf_shift)
         noshift:     frf_shifted = frf_data;
         shift_right: frf_shifted = {{word_w{1'b0}}, frf_data[data_w-1:word_w]};
         shift_left:  frf_shifted = {frf_data[word_w-1:0], {word_w{1'b0}}};
         default:     frf_shifted = '0;
      endcase
   end

   assign frf_aligned[data_w-1:word_w] = frf_shifted[data_w-1:word_w];
   assign frf_aligned[word_w-1:0]      = zero_low32 ? '0 : frf_shifted[word_w-1:0];

   // return mux, flips move a single into the other half
   always_comb begin
      case (ret_sel)
         lsu_noflip: ret_data = ld_d1;
         lsu_flip:   ret_data = {ld_d1[word_w-1:0], {word_w{1'b0}}};
         fpu_noflip: ret_data = fpu_d1;
         fpu_flip:   ret_data = {{word_w{1'b0}}, fpu_d1[data_w-1:word_w]};
         default:    ret_data = '0;
      endcase
   end

   // encoding 3 has no alignment behind it
   a_frf_shift_legal: assert property (
      @(posedge rclk) disable iff (!rst_n)
      frf_shift inside {noshift, shift_right, shift_left}
   );

endmodule

/* src/ffu_operand_regs.sv */
module ffu_operand_regs
   import ffu_dp_pkg::*;
(
   input  logic              rclk,
   input  logic              rst_n,
   input  logic [data_w-1:0] frf_aligned,
   input  logic [data_w-1:0] ret_data,
   input  rs2_sel_e          rs2_sel,
   input  logic              new_rs1,
   input  logic [1:0]        sign,          // sign after fabs / fneg
   output logic [data_w-1:0] rs1_data,
   output logic [data_w-1:0] rs2_data,
   output logic [1:0]        rs2_sign,
   output logic [data_w-1:0] frf_wr_data
);

   logic [data_w-1:0] rs2_chg;   // frf data with new signs
   logic [data_w-1:0] rs2_nxt;

   ////////////////////////////////////////////////////////////////////////////
   // rs1
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         rs1_data <= '0;
      end else if (new_rs1) begin
         rs1_data <= frf_aligned;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // rs2 / rd
   ////////////////////////////////////////////////////////////////////////////
   // original sign bits go back to control for fabs/fneg
   assign rs2_sign = {frf_aligned[data_w-1], frf_aligned[word_w-1]};

   always_comb begin
      rs2_chg             = frf_aligned;
      rs2_chg[data_w-1]   = sign[1];   // double, or upper single
      rs2_chg[word_w-1]   = sign[0];   // lower single
   end

   // the enum literal is shadowed by the port of the same name
   always_comb begin
      case (rs2_sel)
         frf_read:             rs2_nxt = rs2_chg;
         ffu_dp_pkg::ret_data: rs2_nxt = ret_data;
         keep:                 rs2_nxt = rs2_data;
         default:              rs2_nxt = rs2_data;
      endcase
   end

   // write data trails rs2 by a cycle so block loads can overlap
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         rs2_data    <= '0;
         frf_wr_data <= '0;
      end else begin
         rs2_data    <= rs2_nxt;
         frf_wr_data <= rs2_data;
      end
   end

   a_rs2_sel_legal: assert property (
      @(posedge rclk) disable iff (!rst_n)
      rs2_sel inside {frf_read, ffu_dp_pkg::ret_data, keep}
   );

endmodule

/* src/ffu_fsr_file.sv */
module ffu_fsr_file
   import ffu_dp_pkg::*;
   import fsr_pkg::*;
(
   input  logic                        rclk,
   input  logic                        rst_n,
   input  fsr_op_e                     fsr_op,
   input  logic [thr_w-1:0]            fsr_upd_thr,
   input  logic [thr_w-1:0]            cur_thr,
   input  logic [data_w-1:0]           ld_d1,
   input  logic [fcc_hi_w+fcc0_w-1:0]  fcc_w2,
   input  logic [ftt_w-1:0]            ftt_w2,
   input  logic [2*exc_w-1:0]          exc_w2,    // aexc, cexc
   output logic [fsr_w-1:0]            cur_fsr,
   output logic [fcc_hi_w+fcc0_w-1:0]  fsr_fcc,
   output logic [rnd_w-1:0]            fsr_rnd,
   output logic [tem_w-1:0]            fsr_tem,
   output logic [exc_w-1:0]            fsr_aexc,
   output logic [exc_w-1:0]            fsr_cexc
);

   logic [fsr_w-1:0] fsr_q [n_thr];
   logic [fsr_w-1:0] upd_old;    // fsr of the thread being written
   logic [fsr_w-1:0] ld_word;
   logic [fsr_w-1:0] fpu_word;
   logic [fsr_w-1:0] upd_word;

   ////////////////////////////////////////////////////////////////////////////
   // update words
   ////////////////////////////////////////////////////////////////////////////
   assign upd_old = fsr_q[fsr_upd_thr];

   // ldfsr / ldxfsr, ftt is not loadable
   always_comb begin
      ld_word                           = upd_old;
      ld_word[fcc_hi_lsb +: fcc_hi_w]   = fcc_w2[fcc0_w +: fcc_hi_w];
      ld_word[rnd_lsb +: rnd_w]         = ld_d1[arch_rnd_lsb +: rnd_w];
      ld_word[tem_lsb +: tem_w]         = ld_d1[arch_tem_lsb +: tem_w];
      ld_word[arch_low_w-1:0]           = ld_d1[arch_low_w-1:0];   // fcc0, aexc, cexc
   end

   // fpu completion keeps rnd and tem
   always_comb begin
      fpu_word                          = upd_old;
      fpu_word[fcc_hi_lsb +: fcc_hi_w]  = fcc_w2[fcc0_w +: fcc_hi_w];
      fpu_word[ftt_lsb +: ftt_w]        = ftt_w2;
      fpu_word[fcc0_lsb +: fcc0_w]      = fcc_w2[fcc0_w-1:0];
      fpu_word[cexc_lsb +: 2*exc_w]     = exc_w2;
   end

   always_comb begin
      case (fsr_op)
         fsr_ld:  upd_word = ld_word;
         fsr_fpu: upd_word = fpu_word;
         default: upd_word = upd_old;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // per-thread fsr storage
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         for (int t = 0; t < n_thr; t++) begin
            fsr_q[t] <= '0;
         end
      end else if (fsr_op != fsr_hold) begin
         fsr_q[fsr_upd_thr] <= upd_word;   // only the addressed thread
      end
   end

   // current thread read
   assign cur_fsr  = fsr_q[cur_thr];
   assign fsr_fcc  = {cur_fsr[fcc_hi_lsb +: fcc_hi_w], cur_fsr[fcc0_lsb +: fcc0_w]};
   assign fsr_rnd  = cur_fsr[rnd_lsb +: rnd_w];
   assign fsr_tem  = cur_fsr[tem_lsb +: tem_w];
   assign fsr_aexc = cur_fsr[aexc_lsb +: exc_w];
   assign fsr_cexc = cur_fsr[cexc_lsb +: exc_w];

   a_fsr_op_legal: assert property (
      @(posedge rclk) disable iff (!rst_n)
      fsr_op inside {fsr_hold, fsr_ld, fsr_fpu}
   );

endmodule

/* src/ffu_output_sel.sv */
module ffu_output_sel
   import ffu_dp_pkg::*;
   import fsr_pkg::*;
(
   input  out_sel_e          out_sel,
   input  logic [data_w-1:0] rs1_data,
   input  logic [data_w-1:0] rs2_data,
   input  logic [data_w-1:0] frf_aligned,
   input  logic [fsr_w-1:0]  cur_fsr,
   output logic [data_w-1:0] lsu_data
);

   logic [data_w-1:0] fsr_img;

   ////////////////////////////////////////////////////////////////////////////
   // fsr expansion for stfsr
   ////////////////////////////////////////////////////////////////////////////
   // reserved, ver, ns and qne all read zero
   always_comb begin
      fsr_img                                    = '0;
      fsr_img[arch_fcc_hi_lsb +: fcc_hi_w]       = cur_fsr[fcc_hi_lsb +: fcc_hi_w];
      fsr_img[arch_rnd_lsb +: rnd_w]             = cur_fsr[rnd_lsb +: rnd_w];
      fsr_img[arch_tem_lsb +: tem_w]             = cur_fsr[tem_lsb +: tem_w];
      fsr_img[arch_ftt_lsb +: ftt_w]             = cur_fsr[ftt_lsb +: ftt_w];
      fsr_img[arch_low_w-1:0]                    = cur_fsr[arch_low_w-1:0];
   end

   // store data to lsu
   always_comb begin
      case (out_sel)
         sel_rs2: lsu_data = rs2_data;
         sel_rs1: lsu_data = rs1_data;
         sel_frf: lsu_data = frf_aligned;   // direct frf store path
         sel_fsr: lsu_data = fsr_img;
         default: lsu_data = '0;
      endcase
   end

endmodule

/* src/ffu_dp.sv */
module ffu_dp
   import ffu_dp_pkg::*;
   import fsr_pkg::*;
(
   input  logic                        rclk,
   input  logic                        rst_n,
   input  logic [data_w-1:0]           frf_data,
   input  frf_shift_e                  frf_shift,
   input  logic                        zero_low32,
   input  logic [data_w-1:0]           cpx_fpu_data,
   input  logic [data_w-1:0]           lsu_ld_data,
   input  ret_sel_e                    ret_sel,
   input  rs2_sel_e                    rs2_sel,
   input  logic                        new_rs1,
   input  logic [1:0]                  sign,
   input  fsr_op_e                     fsr_op,
   input  logic [thr_w-1:0]            fsr_upd_thr,
   input  logic [fcc_hi_w+fcc0_w-1:0]  fcc_w2,
   input  logic [ftt_w-1:0]            ftt_w2,
   input  logic [2*exc_w-1:0]          exc_w2,
   input  logic [thr_w-1:0]            cur_thr,
   input  out_sel_e                    out_sel,
   output logic [data_w-1:0]           frf_wr_data,
   output logic [data_w-1:0]           lsu_data,
   output logic [1:0]                  rs2_sign,
   output logic [fcc_hi_w+fcc0_w-1:0]  ld_fcc,
   output logic [fcc_hi_w+fcc0_w-1:0]  fsr_fcc,
   output logic [rnd_w-1:0]            fsr_rnd,
   output logic [tem_w-1:0]            fsr_tem,
   output logic [exc_w-1:0]            fsr_aexc,
   output logic [exc_w-1:0]            fsr_cexc
);

   logic [data_w-1:0] frf_aligned;
   logic [data_w-1:0] ret_word;     // flipped return data
   logic [data_w-1:0] ld_d1;
   logic [data_w-1:0] rs1_data;
   logic [data_w-1:0] rs2_data;
   logic [fsr_w-1:0]  cur_fsr;

   ffu_input_align u_input_align (
      .rclk, .rst_n, .frf_data, .frf_shift, .zero_low32, .cpx_fpu_data, .lsu_ld_data,
      .ret_sel, .frf_aligned, .ret_data(ret_word), .ld_d1, .ld_fcc
   );

   ffu_operand_regs u_operand_regs (
      .rclk, .rst_n, .frf_aligned, .ret_data(ret_word), .rs2_sel, .new_rs1, .sign,
      .rs1_data, .rs2_data, .rs2_sign, .frf_wr_data
   );

   ffu_fsr_file u_fsr_file (
      .rclk, .rst_n, .fsr_op, .fsr_upd_thr, .cur_thr, .ld_d1, .fcc_w2, .ftt_w2, .exc_w2,
      .cur_fsr, .fsr_fcc, .fsr_rnd, .fsr_tem, .fsr_aexc, .fsr_cexc
   );

   ffu_output_sel u_output_sel (
      .out_sel, .rs1_data, .rs2_data, .frf_aligned, .cur_fsr, .lsu_data
   );

endmodule

/* sim/ffu_dp_checker.sv */
module ffu_dp_checker
   import ffu_dp_pkg::*;
   import fsr_pkg::*;
(
   input  logic        rclk, rst_n, zero_low32, new_rs1, stim_done,
   input  logic [63:0] frf_data, cpx_fpu_data, lsu_ld_data, frf_wr_data, lsu_data,
   input  logic [1:0]  frf_shift, ret_sel, rs2_sel, sign, fsr_op,
   input  logic [1:0]  fsr_upd_thr, cur_thr, out_sel, rs2_sign, fsr_rnd,
   input  logic [7:0]  fcc_w2, ld_fcc, fsr_fcc,
   input  logic [2:0]  ftt_w2,
   input  logic [9:0]  exc_w2,
   input  logic [4:0]  fsr_tem, fsr_aexc, fsr_cexc,
   output bit          done,
   output int          err_cnt, check_cnt
);

   logic [63:0] m_ld, m_fpu, m_rs1, m_rs2, m_wr;   // expected register contents
   logic [27:0] m_fsr [4];

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [63:0] align_frf(input logic [63:0] d, input logic [1:0] sh,
                                             input logic zl);
      logic [63:0] a;
      case (sh)
         shift_right: a = {32'h0, d[63:32]};
         shift_left:  a = {d[31:0], 32'h0};
         default:     a = d;
      endcase
      if (zl) a[31:0] = 32'h0;
      return a;
   endfunction

   function automatic logic [63:0] pick_return(input logic [63:0] ld, input logic [63:0] fpu,
                                               input logic [1:0] sel);
      case (sel)
         lsu_flip:   return {ld[31:0], 32'h0};
         fpu_noflip: return fpu;
         fpu_flip:   return {32'h0, fpu[63:32]};
         default:    return ld;
      endcase
   endfunction

   // stored layout: fcc3..1, rnd, tem, ftt, fcc0, aexc, cexc
   function automatic logic [27:0] fsr_update(input logic [27:0] old, input logic [1:0] op,
                                              input logic [63:0] ld, input logic [7:0] fcc,
                                              input logic [2:0] ftt, input logic [9:0] exc);
      logic [27:0] f;
      f = old;
      if (op == fsr_ld) begin
         f[27:22] = fcc[7:2];
         f[21:20] = ld[31:30];
         f[19:15] = ld[27:23];
         f[11:0]  = ld[11:0];    // ftt stays
      end else if (op == fsr_fpu) begin
         f[27:22] = fcc[7:2];
         f[14:12] = ftt;
         f[11:10] = fcc[1:0];
         f[9:0]   = exc;
      end
      return f;
   endfunction

   function automatic logic [63:0] fsr_image(input logic [27:0] f);
      return {26'h0, f[27:22], f[21:20], 2'b00, f[19:15], 6'h0, f[14:12], 2'b00, f[11:0]};
   endfunction

   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // compare, then advance the model by one clock
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge rclk) begin : compare_proc
      logic [63:0] aligned;
      logic [63:0] exp_lsu;
      logic [63:0] nxt_rs2;
      logic [27:0] cf;
      if (!rst_n) begin
         {m_ld, m_fpu, m_rs1, m_rs2, m_wr} = '0;
         for (int t = 0; t < 4; t++) begin
            m_fsr[t] = '0;
         end
         err_cnt   = 0;
         check_cnt = 0;
         done     <= 1'b0;
      end else begin
         aligned = align_frf(frf_data, frf_shift, zero_low32);
         cf      = m_fsr[cur_thr];
         case (out_sel)
            sel_rs1: exp_lsu = m_rs1;
            sel_frf: exp_lsu = aligned;
            sel_fsr: exp_lsu = fsr_image(cf);
            default: exp_lsu = m_rs2;
         endcase
         compare_value("lsu_data", lsu_data, exp_lsu);
         compare_value("frf_wr_data", frf_wr_data, m_wr);
         compare_value("rs2_sign", 64'(rs2_sign), 64'({aligned[63], aligned[31]}));
         compare_value("ld_fcc", 64'(ld_fcc), 64'({m_ld[37:32], m_ld[11:10]}));
         compare_value("fsr_fcc", 64'(fsr_fcc), 64'({cf[27:22], cf[11:10]}));
         compare_value("fsr_rnd", 64'(fsr_rnd), 64'(cf[21:20]));
         compare_value("fsr_tem", 64'(fsr_tem), 64'(cf[19:15]));
         compare_value("fsr_aexc", 64'(fsr_aexc), 64'(cf[9:5]));
         compare_value("fsr_cexc", 64'(fsr_cexc), 64'(cf[4:0]));

         case (rs2_sel)
            frf_read: nxt_rs2 = {sign[1], aligned[62:32], sign[0], aligned[30:0]};
            ret_data: nxt_rs2 = pick_return(m_ld, m_fpu, ret_sel);
            default:  nxt_rs2 = m_rs2;
         endcase
         m_wr  = m_rs2;   // write-back trails rs2
         m_rs2 = nxt_rs2;
         if (new_rs1) m_rs1 = aligned;
         m_fsr[fsr_upd_thr] = fsr_update(m_fsr[fsr_upd_thr], fsr_op, m_ld, fcc_w2, ftt_w2,
                                         exc_w2);
         m_ld  = lsu_ld_data;
         m_fpu = cpx_fpu_data;
         if (stim_done) done <= 1'b1;
      end
   end

endmodule

/* sim/tb_ffu_dp.sv */
module tb_ffu_dp
   import ffu_dp_pkg::*;
   import fsr_pkg::*;
();

   logic        rclk = 1'b0;
   logic        rst_n, zero_low32, new_rs1;
   logic [63:0] frf_data, cpx_fpu_data, lsu_ld_data;
   frf_shift_e  frf_shift;
   ret_sel_e    ret_sel;
   rs2_sel_e    rs2_sel;
   fsr_op_e     fsr_op;
   out_sel_e    out_sel;
   logic [1:0]  sign, fsr_upd_thr, cur_thr;
   logic [7:0]  fcc_w2;
   logic [2:0]  ftt_w2;
   logic [9:0]  exc_w2;
   logic [63:0] frf_wr_data, lsu_data;
   logic [1:0]  rs2_sign, fsr_rnd;
   logic [7:0]  ld_fcc, fsr_fcc;
   logic [4:0]  fsr_tem, fsr_aexc, fsr_cexc;
   logic        stim_done = 1'b0;
   bit          done;
   int          err_cnt, check_cnt;
   int          other_errs = 0;
   logic [31:0] seed = 32'hcea0;

   always #4 rclk = ~rclk;

   ffu_dp DUT (.*);
   ffu_dp_checker u_checker (.*);

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // one cycle of random inputs, selects kept to legal codes
   task automatic drive_random();
      logic [31:0] r [8];
      for (int i = 0; i < 8; i++) begin
         seed = lcg_next(seed);
         r[i] = seed;
      end
      frf_data     <= {r[0], r[1]};
      lsu_ld_data  <= {r[2], r[3]};
      cpx_fpu_data <= {r[4], r[5]};
      frf_shift    <= frf_shift_e'(2'(r[6][31:24] % 8'd3));
      rs2_sel      <= rs2_sel_e'(2'(r[6][23:16] % 8'd3));
      fsr_op       <= fsr_op_e'(2'(r[6][15:8] % 8'd3));
      exc_w2       <= {r[6][7:0], r[7][8:7]};
      ret_sel      <= ret_sel_e'(r[7][31:30]);
      sign         <= r[7][29:28];
      fsr_upd_thr  <= r[7][27:26];
      cur_thr      <= r[7][25:24];
      out_sel      <= out_sel_e'(r[7][23:22]);
      zero_low32   <= r[7][21];
      new_rs1      <= r[7][20];
      fcc_w2       <= r[7][19:12];
      ftt_w2       <= r[7][11:9];
   endtask

   // no register loads this cycle
   task automatic freeze_regs();
      new_rs1 <= 1'b0;
      rs2_sel <= keep;
      fsr_op  <= fsr_hold;
   endtask

   initial begin
      int waited;
      rst_n = 1'b0;
      drive_random();
      freeze_regs();
      repeat (5) @(posedge rclk);
      rst_n <= 1'b1;

      // reset values on every output path
      for (int i = 0; i < 4; i++) begin
         @(posedge rclk);
         drive_random();
         freeze_regs();
         out_sel <= out_sel_e'(2'(i));
         cur_thr <= 2'(i);
      end

      ////////////////////////////////////////////////////////////////////////////
      // directed sweeps
      ////////////////////////////////////////////////////////////////////////////
      for (int i = 0; i < 6; i++) begin
         @(posedge rclk);
         drive_random();
         frf_shift  <= frf_shift_e'(2'(i % 3));
         zero_low32 <= (i >= 3);
         new_rs1    <= 1'b1;
         out_sel    <= sel_frf;
         @(posedge rclk);
         drive_random();
         new_rs1 <= 1'b0;
         out_sel <= sel_rs1;       // rs1 from the cycle before
      end
      for (int i = 0; i < 8; i++) begin
         @(posedge rclk);
         drive_random();
         rs2_sel <= (i % 4 == 3) ? keep : frf_read;
         out_sel <= sel_rs2;
      end
      for (int i = 0; i < 8; i++) begin
         @(posedge rclk);
         drive_random();
         ret_sel <= ret_sel_e'(2'(i % 4));
         rs2_sel <= ret_data;
         out_sel <= sel_rs2;
      end
      for (int i = 0; i < 60; i++) begin
         @(posedge rclk);
         drive_random();
         out_sel <= sel_fsr;
      end
      for (int i = 0; i < 4; i++) begin
         @(posedge rclk);
         drive_random();
         fsr_op  <= fsr_hold;
         cur_thr <= 2'(i);
         out_sel <= sel_fsr;
      end
      for (int i = 0; i < 300; i++) begin
         @(posedge rclk);
         drive_random();
      end

      @(posedge rclk);
      freeze_regs();
      stim_done <= 1'b1;
      waited = 0;
      while (!done && waited < 16) begin
         @(negedge rclk);          // counts settled, no compare in flight
         waited++;
      end
      if (!done) begin
         $display("timeout: checker did not finish within 16 cycles");
         other_errs++;
      end
      $display("checks %0d  mismatches %0d  other errors %0d", check_cnt, err_cnt, other_errs);
      if (err_cnt == 0 && other_errs == 0 && check_cnt > 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* ffu_dp.f */
src/ffu_dp_pkg.sv
src/fsr_pkg.sv
src/ffu_input_align.sv
src/ffu_operand_regs.sv
src/ffu_fsr_file.sv
src/ffu_output_sel.sv
src/ffu_dp.sv
sim/ffu_dp_checker.sv
sim/tb_ffu_dp.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ffu_dp testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ffu_dp -f ffu_dp.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ffu_dp)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
